/* design/lsu_pkg.sv */
//--------------------------------------------------------------------------
// LSU package
// Widths, funct3 opcodes and byte-lane types for the RV32 load/store unit
//--------------------------------------------------------------------------

package lsu_pkg;

    //--------------------------------------------------------------------------
    // Widths
    //--------------------------------------------------------------------------

    // One RV32 word
    localparam int XLEN           = 32;

    // Lanes per word and bits per lane
    localparam int BYTES_PER_WORD = XLEN / 8;
    localparam int BYTE_W         = 8;

    // Byte offset inside a word
    localparam int OFFSET_W       = $clog2(BYTES_PER_WORD);

    //--------------------------------------------------------------------------
    // Data types
    //--------------------------------------------------------------------------

    // Address or data word
    typedef logic [XLEN-1:0]           lsu_word_t;

    // Single lane and lane pair for load extension
    typedef logic [BYTE_W-1:0]         lsu_byte_t;
    typedef logic [2*BYTE_W-1:0]       lsu_half_t;

    // Per-lane write strobes
    typedef logic [BYTES_PER_WORD-1:0] lsu_be_t;

    // Lane index of the first accessed byte
    typedef logic [OFFSET_W-1:0]       lsu_offset_t;

    //--------------------------------------------------------------------------
    // Lane masks before shifting to the offset
    //--------------------------------------------------------------------------

    localparam lsu_be_t BE_BYTE = 4'b0001;
    localparam lsu_be_t BE_HALF = 4'b0011;
    localparam lsu_be_t BE_WORD = 4'b1111;

    //--------------------------------------------------------------------------
    // Opcodes
    //--------------------------------------------------------------------------

    // funct3 field of RV32 loads and stores.
    // Codes 3, 6 and 7 have no name and are trapped by the issue stage
    typedef enum logic [2:0] {
        LSU_B  = 3'b000,
        LSU_H  = 3'b001,
        LSU_W  = 3'b010,
        LSU_BU = 3'b100,
        LSU_HU = 3'b101
    } lsu_funct3_e;

endpackage

/* design/lsu_stage_if.sv */
//--------------------------------------------------------------------------
// LSU stage link
// Carries one decoded access from the issue stage to the result stage
//--------------------------------------------------------------------------

interface lsu_stage_if;
    import lsu_pkg::*;

    // Handshake
    logic        valid;
    logic        ready;

    // Decoded item
    lsu_funct3_e funct3;
    lsu_offset_t offset;
    logic        is_load;
    // Misaligned or illegal access
    logic        err;

    modport issue (
        output valid,
        output funct3,
        output offset,
        output is_load,
        output err,
        input  ready
    );

    modport result (
        input  valid,
        input  funct3,
        input  offset,
        input  is_load,
        input  err,
        output ready
    );

endinterface

/* design/lsu_issue.sv */
//--------------------------------------------------------------------------
// LSU issue stage
// Accepts a request, decodes and traps it, and drives the data memory
//--------------------------------------------------------------------------

module lsu_issue (
    input  logic                 vif,
    input  logic                 arst_n_i,

    // Request from the core
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  lsu_pkg::lsu_word_t   addr_i,
    input  lsu_pkg::lsu_word_t   wdata_i,
    input  logic                 we_i,
    input  lsu_pkg::lsu_funct3_e funct3_i,

    // Data memory
    output lsu_pkg::lsu_word_t   dmem_addr_o,
    output lsu_pkg::lsu_word_t   dmem_wdata_o,
    output lsu_pkg::lsu_be_t     dmem_be_o,
    output logic                 dmem_we_o,

    // Link to the result stage
    lsu_stage_if.issue           stage
);
    import lsu_pkg::*;

    lsu_offset_t req_offset;
    logic        misaligned;
    logic        illegal;
    lsu_be_t     req_be;
    lsu_word_t   req_wdata;

    logic        accept;
    logic        xfer;

    // Issue register
    logic        valid_q;
    lsu_word_t   addr_q;
    lsu_word_t   wdata_q;
    lsu_be_t     be_q;
    lsu_offset_t offset_q;
    lsu_funct3_e funct3_q;
    logic        is_load_q;
    logic        err_q;

    //--------------------------------------------------------------------------
    // Decode
    //--------------------------------------------------------------------------

    assign req_offset = addr_i[OFFSET_W-1:0];

    always_comb begin
        misaligned = 1'b0;
        illegal    = 1'b0;
        req_be     = BE_BYTE << req_offset;
        case (funct3_i)
            LSU_B, LSU_BU: begin
                req_be = BE_BYTE << req_offset;
            end
            LSU_H, LSU_HU: begin
                // Halves must sit on an even lane
                misaligned = req_offset[0];
                req_be     = BE_HALF << req_offset;
            end
            LSU_W: begin
                misaligned = (req_offset != '0);
                req_be     = BE_WORD;
            end
            default: begin
                illegal = 1'b1;
                req_be  = '0;
            end
        endcase
        // No unsigned store forms
        if (we_i && (funct3_i == LSU_BU || funct3_i == LSU_HU)) begin
            illegal = 1'b1;
        end
    end

    // Store data moved up to its lanes
    assign req_wdata = wdata_i << (BYTE_W * req_offset);

    //--------------------------------------------------------------------------
    // Handshake and register
    //--------------------------------------------------------------------------

    assign xfer        = valid_q & stage.ready;
    assign req_ready_o = ~valid_q | stage.ready;
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge vif or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (xfer) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge vif) begin
        if (accept) begin
            addr_q    <= {addr_i[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
            wdata_q   <= req_wdata;
            be_q      <= req_be;
            offset_q  <= req_offset;
            funct3_q  <= funct3_i;
            is_load_q <= ~we_i;
            err_q     <= misaligned | illegal;
        end
    end

    //--------------------------------------------------------------------------
    // Outputs
    //--------------------------------------------------------------------------

    assign stage.valid   = valid_q;
    assign stage.funct3  = funct3_q;
    assign stage.offset  = offset_q;
    assign stage.is_load = is_load_q;
    assign stage.err     = err_q;

    // Memory write happens once on the edge the store leaves this stage
    assign dmem_addr_o  = addr_q;
    assign dmem_wdata_o = wdata_q;
    assign dmem_be_o    = be_q;
    assign dmem_we_o    = xfer & ~is_load_q & ~err_q;

    // A store that leaves with no new request behind it writes only once
    a_we_once : assert property (@(posedge vif) disable iff (!arst_n_i)
        dmem_we_o && !accept |=> !dmem_we_o)
        else $error("dmem write repeated for one store");

    a_we_has_be : assert property (@(posedge vif) disable iff (!arst_n_i)
        dmem_we_o |-> dmem_be_o != '0)
        else $error("dmem write with no byte enable");

endmodule

/* design/lsu_result.sv */
//--------------------------------------------------------------------------
// LSU result stage
// Extracts and extends load data and holds the response for writeback
//--------------------------------------------------------------------------

module lsu_result (
    input  logic               vif,
    input  logic               arst_n_i,

    // Asynchronous read data for the item leaving the issue stage
    input  lsu_pkg::lsu_word_t dmem_rdata_i,

    // Writeback
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output lsu_pkg::lsu_word_t rdata_o,
    output logic               err_o,

    // Link from the issue stage
    lsu_stage_if.result        stage
);
    import lsu_pkg::*;

    logic      xfer;
    lsu_word_t shifted;
    lsu_byte_t sel_byte;
    lsu_half_t sel_half;
    lsu_word_t load_val;

    // Output register
    logic      rsp_valid_q;
    lsu_word_t rdata_q;
    logic      err_q;

    //--------------------------------------------------------------------------
    // Handshake
    //--------------------------------------------------------------------------

    // Ready when the slot is free or its response leaves this cycle
    assign stage.ready = ~rsp_valid_q | rsp_ready_i;
    assign xfer        = stage.valid & stage.ready;

    //--------------------------------------------------------------------------
    // Lane extraction
    //--------------------------------------------------------------------------

    always_comb begin
        shifted  = dmem_rdata_i >> (BYTE_W * stage.offset);
        sel_byte = shifted[BYTE_W-1:0];
        sel_half = shifted[2*BYTE_W-1:0];
        case (stage.funct3)
            LSU_B: begin
                load_val = {{(XLEN-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
            end
            LSU_BU: begin
                load_val = {{(XLEN-BYTE_W){1'b0}}, sel_byte};
            end
            LSU_H: begin
                load_val = {{(XLEN-2*BYTE_W){sel_half[2*BYTE_W-1]}}, sel_half};
            end
            LSU_HU: begin
                load_val = {{(XLEN-2*BYTE_W){1'b0}}, sel_half};
            end
            LSU_W: begin
                load_val = shifted;
            end
            default: begin
                load_val = '0;
            end
        endcase
        // Stores and trapped accesses return zero
        if (!stage.is_load || stage.err) begin
            load_val = '0;
        end
    end

    //--------------------------------------------------------------------------
    // Response register
    //--------------------------------------------------------------------------

    always_ff @(posedge vif or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (xfer) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge vif) begin
        if (xfer) begin
            rdata_q <= load_val;
            err_q   <= stage.err;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;
    assign err_o       = err_q;

    // Stalled response stays put until writeback takes it
    a_rsp_stable : assert property (@(posedge vif) disable iff (!arst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rdata_o) && $stable(err_o))
        else $error("response changed under back-pressure");

endmodule

/* design/lsu_top.sv */
//--------------------------------------------------------------------------
// LSU top level
// RV32 load/store unit built from an issue stage and a result stage
//--------------------------------------------------------------------------

module lsu_top (
    input  logic                 vif,
    input  logic                 arst_n_i,

    // Core request
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  lsu_pkg::lsu_word_t   addr_i,
    input  lsu_pkg::lsu_word_t   wdata_i,
    input  logic                 we_i,
    input  lsu_pkg::lsu_funct3_e funct3_i,

    // Writeback response
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output lsu_pkg::lsu_word_t   rdata_o,
    output logic                 err_o,

    // Data memory with asynchronous read
    output lsu_pkg::lsu_word_t   dmem_addr_o,
    output lsu_pkg::lsu_word_t   dmem_wdata_o,
    output lsu_pkg::lsu_be_t     dmem_be_o,
    output logic                 dmem_we_o,
    input  lsu_pkg::lsu_word_t   dmem_rdata_i
);

    // Issue to result link
    lsu_stage_if stage_if ();

    //--------------------------------------------------------------------------
    // Stages
    //--------------------------------------------------------------------------

    lsu_issue u_issue (
        .vif          (vif),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .we_i         (we_i),
        .funct3_i     (funct3_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_we_o    (dmem_we_o),
        .stage        (stage_if)
    );

    // Read data belongs to the item held in u_issue
    lsu_result u_result (
        .vif          (vif),
        .arst_n_i     (arst_n_i),
        .dmem_rdata_i (dmem_rdata_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rdata_o      (rdata_o),
        .err_o        (err_o),
        .stage        (stage_if)
    );

endmodule

/* bench/tb_lsu_tests.svh */
//--------------------------------------------------------------------------
// LSU directed tests, prediction and request driver
//--------------------------------------------------------------------------

function automatic lsu_word_t make_addr(input logic [5:0] idx, input logic [1:0] off);
    return {24'h0, idx, off};
endfunction

function logic [5:0] rand_index();
    logic [31:0] r;
    r = rand_bits(6);
    return r[5:0];
endfunction

// Expected response by the RV32 rules
// Legal stores also update the shadow
task automatic predict(input lsu_word_t addr, input lsu_word_t wdata, input logic we,
                       input lsu_funct3_e f3, output lsu_word_t data, output logic err);
    int        ofs;
    int        idx;
    int        nbytes;
    logic      legal;
    logic      signed_ld;
    lsu_word_t v;
    ofs       = int'(addr[1:0]);
    idx       = int'(addr[7:2]);
    nbytes    = 1;
    legal     = 1'b0;
    signed_ld = 1'b0;
    v         = '0;
    case (f3)
        LSU_B: begin
            nbytes    = 1;
            legal     = 1'b1;
            signed_ld = 1'b1;
        end
        LSU_BU: begin
            nbytes = 1;
            legal  = !we;
        end
        LSU_H: begin
            nbytes    = 2;
            legal     = (ofs % 2 == 0);
            signed_ld = 1'b1;
        end
        LSU_HU: begin
            nbytes = 2;
            legal  = !we && (ofs % 2 == 0);
        end
        LSU_W: begin
            nbytes = 4;
            legal  = (ofs == 0);
        end
        default: legal = 1'b0;
    endcase
    data = '0;
    err  = !legal;
    if (legal && we) begin
        for (int k = 0; k < nbytes; k++) begin
            shadow[idx][8*(ofs+k) +: 8] = wdata[8*k +: 8];
        end
    end else if (legal) begin
        for (int k = 0; k < nbytes; k++) begin
            v[8*k +: 8] = shadow[idx][8*(ofs+k) +: 8];
        end
        for (int j = 8 * nbytes; j < 32; j++) begin
            v[j] = signed_ld ? v[8*nbytes-1] : 1'b0;
        end
        data = v;
    end
endtask

// Queue the expectation and hold the request until it is accepted
task automatic send(input lsu_word_t addr, input lsu_word_t wdata, input logic we,
                    input lsu_funct3_e f3);
    lsu_word_t exp_data;
    logic      exp_err;
    logic      done;
    predict(addr, wdata, we, f3, exp_data, exp_err);
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_f3_q.push_back(f3);
    done = 1'b0;
    @(negedge vif);
    req_valid_i = 1'b1;
    addr_i      = addr;
    wdata_i     = wdata;
    we_i        = we;
    funct3_i    = f3;
    while (!done) begin
        #10;
        if (req_ready_o) begin
            done = 1'b1;
        end else begin
            @(negedge vif);
        end
    end
    @(posedge vif);
    req_count++;
endtask

// Idle the request side and wait for every open response
task automatic drain(input string name);
    @(negedge vif);
    req_valid_i = 1'b0;
    while (exp_data_q.size() != 0) begin
        @(negedge vif);
    end
    repeat (2) @(negedge vif);
    test_count++;
    $display("test %s done, %0d errors", name, err_count - err_base);
    err_base = err_count;
endtask

task automatic store_load_word();
    logic [5:0] idx;
    for (int i = 0; i < N_WORD_ITEMS / 2; i++) begin
        idx = rand_index();
        send(make_addr(idx, 2'd0), rand_bits(32), 1'b1, LSU_W);
        send(make_addr(idx, 2'd0), '0, 1'b0, LSU_W);
    end
    drain("store/load word");
endtask

task automatic sub_word_stores();
    logic [5:0] idx;
    for (int w = 0; w < 4; w++) begin
        idx = rand_index();
        for (int off = 0; off < 4; off++) begin
            send(make_addr(idx, off[1:0]), rand_bits(32), 1'b1, LSU_B);
            send(make_addr(idx, 2'd0), '0, 1'b0, LSU_W);
        end
        for (int off = 0; off < 4; off += 2) begin
            send(make_addr(idx, off[1:0]), rand_bits(32), 1'b1, LSU_H);
            send(make_addr(idx, 2'd0), '0, 1'b0, LSU_W);
        end
    end
    drain("sub-word stores");
endtask

task automatic load_extension();
    logic [5:0] idx;
    lsu_word_t  data;
    for (int w = 0; w < 4; w++) begin
        idx  = rand_index();
        // First word gives both signs in its bytes and in its halves
        data = (w == 0) ? 32'h7f80_ff01 : rand_bits(32);
        send(make_addr(idx, 2'd0), data, 1'b1, LSU_W);
        for (int off = 0; off < 4; off++) begin
            send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_B);
            send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_BU);
        end
        for (int off = 0; off < 4; off += 2) begin
            send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_H);
            send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_HU);
        end
    end
    drain("load extension");
endtask

task automatic trap_accesses();
    logic [5:0]  idx;
    lsu_funct3_e bad_ld [3];
    lsu_funct3_e bad_st [5];
    bad_ld = '{lsu_funct3_e'(3'd3), lsu_funct3_e'(3'd6), lsu_funct3_e'(3'd7)};
    bad_st = '{LSU_BU, LSU_HU, lsu_funct3_e'(3'd3), lsu_funct3_e'(3'd6),
               lsu_funct3_e'(3'd7)};
    idx = rand_index();
    send(make_addr(idx, 2'd0), '0, 1'b0, LSU_W);
    for (int off = 1; off < 4; off += 2) begin
        send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_H);
        send(make_addr(idx, off[1:0]), rand_bits(32), 1'b1, LSU_H);
        send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_HU);
    end
    for (int off = 1; off < 4; off++) begin
        send(make_addr(idx, off[1:0]), '0, 1'b0, LSU_W);
        send(make_addr(idx, off[1:0]), rand_bits(32), 1'b1, LSU_W);
    end
    foreach (bad_ld[i]) begin
        send(make_addr(idx, 2'd0), '0, 1'b0, bad_ld[i]);
    end
    foreach (bad_st[i]) begin
        send(make_addr(idx, 2'd0), rand_bits(32), 1'b1, bad_st[i]);
    end
    // Word must be untouched by any of the trapped stores
    send(make_addr(idx, 2'd0), '0, 1'b0, LSU_W);
    drain("misalignment and illegal codes");
endtask

task automatic backpressure_stress();
    lsu_funct3_e ld_ops [5];
    lsu_funct3_e st_ops [3];
    lsu_funct3_e f3;
    logic [5:0]  idx;
    logic [1:0]  off;
    logic        we;
    logic [31:0] r;
    ld_ops   = '{LSU_B, LSU_BU, LSU_H, LSU_HU, LSU_W};
    st_ops   = '{LSU_B, LSU_H, LSU_W};
    stall_en = 1'b1;
    for (int i = 0; i < N_STRESS_ITEMS; i++) begin
        idx = rand_index();
        r   = rand_bits(1);
        we  = r[0];
        r   = rand_bits(3);
        f3  = we ? st_ops[r % 3] : ld_ops[r % 5];
        r   = rand_bits(2);
        case (f3)
            LSU_B, LSU_BU: off = r[1:0];
            LSU_H, LSU_HU: off = {r[1], 1'b0};
            default:       off = 2'd0;
        endcase
        send(make_addr(idx, off), rand_bits(32), we, f3);
    end
    drain("back-pressure stress");
    stall_en = 1'b0;
endtask

/* bench/tb_lsu.sv */
//--------------------------------------------------------------------------
// LSU testbench
// Drives the load/store unit against a memory model and a shadow copy
//--------------------------------------------------------------------------

module tb_lsu;
    import lsu_pkg::*;

    localparam int MEM_WORDS       = 64;
    localparam int RESET_CYCLES    = 16;
    localparam logic [31:0] SEED   = 32'ha8c7_7512;
    localparam logic [31:0] TAPS   = 32'h8020_0003;

    // Items per test for the watchdog length
    localparam int N_WORD_ITEMS    = 16;
    localparam int N_SUB_ITEMS     = 48;
    localparam int N_EXT_ITEMS     = 52;
    localparam int N_TRAP_ITEMS    = 22;
    localparam int N_STRESS_ITEMS  = 200;
    localparam int CYCLES_PER_ITEM = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + CYCLES_PER_ITEM *
        (N_WORD_ITEMS + N_SUB_ITEMS + N_EXT_ITEMS + N_TRAP_ITEMS + N_STRESS_ITEMS);

    logic        vif = 1'b0;
    logic        arst_n_i;
    logic        req_valid_i;
    logic        req_ready_o;
    lsu_word_t   addr_i;
    lsu_word_t   wdata_i;
    logic        we_i;
    lsu_funct3_e funct3_i;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    lsu_word_t   rdata_o;
    logic        err_o;
    lsu_word_t   dmem_addr_o;
    lsu_word_t   dmem_wdata_o;
    lsu_be_t     dmem_be_o;
    logic        dmem_we_o;
    lsu_word_t   dmem_rdata_i;

    lsu_word_t   mem [MEM_WORDS];
    lsu_word_t   shadow [MEM_WORDS];
    logic [31:0] stim_lfsr;
    logic [31:0] stall_lfsr;
    logic [1:0]  stall_bits;
    logic        stall_en;

    // Expected responses in request order
    lsu_word_t   exp_data_q [$];
    logic        exp_err_q [$];
    lsu_funct3_e exp_f3_q [$];

    int          req_count;
    int          rsp_count;
    int          err_count;
    int          test_count;
    int          err_base;

    always #50 vif = ~vif;

    lsu_top u_dut (
        .vif          (vif),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .we_i         (we_i),
        .funct3_i     (funct3_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rdata_o      (rdata_o),
        .err_o        (err_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

    //--------------------------------------------------------------------------
    // Memory model, LFSR and helpers
    //--------------------------------------------------------------------------

    function automatic lsu_word_t fill_word(input int i);
        logic [7:0] a;
        a = i[7:0];
        return {a ^ 8'h5a, ~a, a + 8'h31, a};
    endfunction

    // Combinational read and byte-enabled write
    assign dmem_rdata_i = mem[dmem_addr_o[7:2]];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge vif);
            if (dmem_we_o) begin
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (dmem_be_o[b]) begin
                        mem[dmem_addr_o[7:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
                    end
                end
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_next(stim_lfsr);
        end
        return v;
    endfunction

    // Writeback stalls about one cycle in four
    initial begin
        rsp_ready_i = 1'b1;
        forever begin
            @(negedge vif);
            if (stall_en) begin
                stall_bits[0] = stall_lfsr[0];
                stall_lfsr    = lfsr_next(stall_lfsr);
                stall_bits[1] = stall_lfsr[0];
                stall_lfsr    = lfsr_next(stall_lfsr);
                rsp_ready_i   = (stall_bits != 2'b00);
            end else begin
                rsp_ready_i = 1'b1;
            end
        end
    end

    //--------------------------------------------------------------------------
    // Compare tasks and response monitor
    //--------------------------------------------------------------------------

    task automatic check_word(input lsu_word_t got, input lsu_word_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input lsu_funct3_e f3);
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t: err got %b, expected %b for funct3 %0d",
                     $time, got, exp, f3);
        end
    endtask

    // Sampled mid-cycle when the handshake is settled
    initial begin
        forever begin
            @(negedge vif);
            #10;
            if (arst_n_i && rsp_valid_o && rsp_ready_i) begin
                rsp_count++;
                if (exp_data_q.size() == 0) begin
                    err_count++;
                    $display("error at %0t: response arrived with no open request", $time);
                end else begin
                    check_word(rdata_o, exp_data_q.pop_front(), "rdata");
                    check_err(err_o, exp_err_q.pop_front(), exp_f3_q.pop_front());
                end
            end
        end
    end

    `include "tb_lsu_tests.svh"

    //--------------------------------------------------------------------------
    // Watchdog and main sequence
    //--------------------------------------------------------------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge vif);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        we_i        = 1'b0;
        funct3_i    = LSU_W;
        stall_en    = 1'b0;
        stim_lfsr   = SEED;
        stall_lfsr  = SEED;
        req_count   = 0;
        rsp_count   = 0;
        err_count   = 0;
        test_count  = 0;
        err_base    = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (RESET_CYCLES) @(posedge vif);
        @(negedge vif);
        arst_n_i = 1'b1;

        store_load_word();
        sub_word_stores();
        load_extension();
        trap_accesses();
        backpressure_stress();

        $display("tests %0d, requests %0d, responses %0d, errors %0d",
                 test_count, req_count, rsp_count, err_count);
        if (err_count == 0 && req_count == rsp_count) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* lsu.f */
+incdir+bench
design/lsu_pkg.sv
design/lsu_stage_if.sv
design/lsu_issue.sv
design/lsu_result.sv
design/lsu_top.sv
bench/tb_lsu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert \
    -f lsu.f \
    --top-module tb_lsu \
    -Mdir "$BUILD_DIR/obj_dir" \
    -o tb_lsu

"./$BUILD_DIR/obj_dir/tb_lsu" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
